//--- source/tlb_cfg.svh
// sizes and constants of the translation buffer
// included by the package and by every module that needs a width or a code
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// set-associative geometry
`define TLB_SETS 64
`define TLB_INDEX_W 6
`define TLB_WAYS 4

// address split, 4 KiB pages
`define TLB_ADDR_W 48
`define TLB_PAGE_W 12
`define TLB_VPN_W 36

// page number sent out on a miss, and the exception it raises
`define TLB_MISS_PAGE 36'h010
`define TLB_EXC_MISS 16'hA001

// top address nibble of the untranslated windows
`define TLB_WIN_PHYS_C 4'hC
`define TLB_WIN_PHYS_D 4'hD
`define TLB_WIN_MMIO 4'hF

`endif

//--- source/tlbPkg.sv
// types shared by the translation buffer RTL and its testbench
// modules take them with a wildcard import in their header
`include "tlb_cfg.svh"

package tlbPkg;

	// ring slot opcodes, IDLE marks an empty slot
	typedef enum logic [7:0] {
		IDLE = 8'h00,
		LDTLB = 8'h01,
		INVTLB = 8'h02,
		LDX = 8'h90,
		STX = 8'hA0
	} tlbOp_e;

	typedef logic [`TLB_INDEX_W-1:0] tlbIndex_t;
	typedef logic [$clog2(`TLB_WAYS)-1:0] tlbWay_t;

	// one slot on the request ring
	typedef struct packed {
		tlbOp_e op;
		logic missFlag;
		logic [15:0] seq;
		logic [`TLB_ADDR_W-1:0] addr;
		logic [127:0] data;
	} memReq_t;

	// translation entry, LDTLB carries it in data[87:0]
	typedef struct packed {
		logic [`TLB_VPN_W-1:0] vpn;
		logic [`TLB_VPN_W-1:0] ppn;
		logic [15:0] asid;
	} tlbEntry_t;

	typedef struct packed {
		logic enable;
		logic [15:0] asid;
	} mmuCtrl_t;

	// code 0 means no exception
	typedef struct packed {
		logic [15:0] code;
		logic [`TLB_ADDR_W-1:0] faultAddr;
	} tlbExc_t;

	// all ways of one set, way 0 is the most recent
	typedef struct packed {
		tlbEntry_t [`TLB_WAYS-1:0] entries;
		logic [`TLB_WAYS-1:0] valid;
	} tlbSet_t;

endpackage

//--- source/tlbWayArray.sv
// storage of one TLB way, one entry per set plus a valid vector
// the read is registered so the set is ready one edge after the index
`include "tlb_cfg.svh"

module tlbWayArray
	import tlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input logic invalidate,
	input tlbIndex_t readIndex,
	input tlbIndex_t writeIndex,
	input logic writeEnable,
	input tlbEntry_t writeEntry,
	input logic writeValid,
	output tlbEntry_t readEntry,
	output logic readValid
);

	tlbEntry_t entries [`TLB_SETS];
	logic [`TLB_SETS-1:0] valid;

	// valid bits are the only control state of the way
	always_ff @(posedge clock)
	begin
		if (reset)
			valid <= '0;
		else if (!hold)
		begin
			if (invalidate)
				valid <= '0;
			else if (writeEnable)
				valid[writeIndex] <= writeValid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold && writeEnable)
			entries[writeIndex] <= writeEntry;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			readEntry <= entries[readIndex];
	end

	// a read at the invalidate edge must not see the old valid bit
	always_ff @(posedge clock)
	begin
		if (reset)
			readValid <= 1'b0;
		else if (!hold)
			readValid <= valid[readIndex] && !invalidate;
	end

endmodule

//--- source/tlbMatch.sv
// tag compare over all ways of the read set
// picks the lowest hitting way and forms the translated address
`include "tlb_cfg.svh"

module tlbMatch
	import tlbPkg::*;
(
	input tlbSet_t set,
	input logic [`TLB_ADDR_W-1:0] addr,
	input logic [15:0] asid,
	output logic hit,
	output tlbWay_t hitWay,
	output logic [`TLB_ADDR_W-1:0] physAddr
);

	logic [`TLB_WAYS-1:0] wayHit;
	logic [`TLB_VPN_W-1:0] vpn;
	logic [`TLB_VPN_W-1:0] hitPpn;

	assign vpn = addr[`TLB_ADDR_W-1:`TLB_PAGE_W];

	// per-way compare of page number and address space
	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
		begin
			wayHit[w] = set.valid[w]
				&& (set.entries[w].vpn == vpn)
				&& (set.entries[w].asid == asid);
		end
	end

	assign hit = |wayHit;

	// walk down so the lowest way wins
	always_comb
	begin
		hitWay = '0;
		for (int w = `TLB_WAYS - 1; w >= 0; w--)
		begin
			if (wayHit[w])
				hitWay = tlbWay_t'(w);
		end
	end

	assign hitPpn = set.entries[hitWay].ppn;

	// physical address keeps the page offset
	always_comb
	begin
		physAddr = {hitPpn, addr[`TLB_PAGE_W-1:0]};
		// low physical memory is reached through the C window
		if (physAddr[`TLB_ADDR_W-1 -: 4] == 4'h0)
			physAddr[`TLB_ADDR_W-1 -: 4] = `TLB_WIN_PHYS_C;
	end

endmodule

//--- source/tlbReplace.sv
// rewrites one set for an LDTLB insert or a hit promotion
// the new set goes to all ways at once, back-to-back writes are dropped
`include "tlb_cfg.svh"

module tlbReplace
	import tlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input memReq_t req,
	input logic lookupActive,
	input tlbSet_t set,
	input logic hit,
	input tlbWay_t hitWay,
	output logic writeEnable,
	output tlbIndex_t writeIndex,
	output tlbSet_t newSet
);

	tlbEntry_t loadEntry;
	logic wantWrite;
	logic lastWrite;

	assign loadEntry = tlbEntry_t'(req.data[$bits(tlbEntry_t)-1:0]);

	// LDTLB indexes by its entry, everything else by the address
	assign writeIndex = (req.op == LDTLB) ? loadEntry.vpn[`TLB_INDEX_W-1:0]
		: req.addr[`TLB_PAGE_W +: `TLB_INDEX_W];

	always_comb
	begin
		newSet = set;
		wantWrite = 1'b0;
		if (req.op == LDTLB)
		begin
			// insert at way 0, last way falls out
			wantWrite = 1'b1;
			newSet.entries[0] = loadEntry;
			newSet.valid[0] = 1'b1;
			for (int w = 1; w < `TLB_WAYS; w++)
			begin
				newSet.entries[w] = set.entries[w-1];
				newSet.valid[w] = set.valid[w-1];
			end
		end
		else if (lookupActive && hit && (hitWay != '0))
		begin
			// move the hit to the front, ways above it stay
			wantWrite = 1'b1;
			newSet.entries[0] = set.entries[hitWay];
			newSet.valid[0] = 1'b1;
			for (int w = 1; w < `TLB_WAYS; w++)
			begin
				if (w <= int'(hitWay))
				begin
					newSet.entries[w] = set.entries[w-1];
					newSet.valid[w] = set.valid[w-1];
				end
			end
		end
	end

	// a set read right after a write is stale, so skip that write
	assign writeEnable = wantWrite && !lastWrite;

	always_ff @(posedge clock)
	begin
		if (reset)
			lastWrite <= 1'b0;
		else if (!hold)
			lastWrite <= writeEnable;
	end

endmodule

//--- source/tlbPipe.sv
// request pipeline of the TLB, one stage register and one output register
// decides per request between translation, miss, window bypass and pass-through
`include "tlb_cfg.svh"

module tlbPipe
	import tlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input mmuCtrl_t ctrl,
	input memReq_t reqIn,
	input logic hit,
	input logic [`TLB_ADDR_W-1:0] physAddr,
	output tlbIndex_t readIndex,
	output memReq_t stageReq,
	output logic lookupActive,
	output logic invalidate,
	output memReq_t reqOut,
	output tlbExc_t excOut
);

	tlbEntry_t inEntry;
	logic [3:0] topNibble;
	logic isAccess;
	logic isPhys;
	logic isMmio;
	memReq_t nextReq;
	tlbExc_t nextExc;

	// set index is taken from the raw input so the arrays read in parallel
	assign inEntry = tlbEntry_t'(reqIn.data[$bits(tlbEntry_t)-1:0]);
	assign readIndex = (reqIn.op == LDTLB) ? inEntry.vpn[`TLB_INDEX_W-1:0]
		: reqIn.addr[`TLB_PAGE_W +: `TLB_INDEX_W];

	always_ff @(posedge clock)
	begin
		if (reset)
			stageReq <= '{op: IDLE, default: '0};
		else if (!hold)
			stageReq <= reqIn;
	end

	// stage 1 decode
	assign topNibble = stageReq.addr[`TLB_ADDR_W-1 -: 4];
	assign isAccess = (stageReq.op == LDX) || (stageReq.op == STX);
	assign isPhys = (topNibble == `TLB_WIN_PHYS_C) || (topNibble == `TLB_WIN_PHYS_D);
	assign isMmio = (topNibble == `TLB_WIN_MMIO);
	assign lookupActive = ctrl.enable && isAccess && !isPhys && !isMmio;
	assign invalidate = (stageReq.op == INVTLB);

	always_comb
	begin
		nextReq = stageReq;
		nextExc = '0;
		if (lookupActive)
		begin
			if (hit)
				nextReq.addr = physAddr;
			else
			begin
				// miss page keeps the offset for the handler
				nextReq.addr = {`TLB_MISS_PAGE, stageReq.addr[`TLB_PAGE_W-1:0]};
				nextReq.missFlag = 1'b1;
				nextExc.code = `TLB_EXC_MISS;
				nextExc.faultAddr = stageReq.addr;
			end
		end
		else if (ctrl.enable && isAccess && isPhys)
			nextReq.addr[`TLB_ADDR_W-1 -: 4] = `TLB_WIN_PHYS_C;
	end

	// exception leaves together with its request
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOut <= '{op: IDLE, default: '0};
			excOut <= '0;
		end
		else if (!hold)
		begin
			reqOut <= nextReq;
			excOut <= nextExc;
		end
	end

endmodule

//--- source/mmuTlb.sv
// top level of the four-way TLB on the request ring
// reqIn is translated into reqOut two non-held edges later
`include "tlb_cfg.svh"

module mmuTlb
	import tlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input mmuCtrl_t ctrl,
	input memReq_t reqIn,
	output memReq_t reqOut,
	output tlbExc_t excOut
);

	tlbIndex_t readIndex;
	tlbIndex_t writeIndex;
	memReq_t stageReq;
	tlbSet_t readSet;
	tlbSet_t newSet;
	tlbWay_t hitWay;
	logic [`TLB_ADDR_W-1:0] physAddr;
	logic lookupActive;
	logic invalidate;
	logic writeEnable;
	logic hit;

	tlbPipe pipe (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.ctrl(ctrl),
		.reqIn(reqIn),
		.hit(hit),
		.physAddr(physAddr),
		.readIndex(readIndex),
		.stageReq(stageReq),
		.lookupActive(lookupActive),
		.invalidate(invalidate),
		.reqOut(reqOut),
		.excOut(excOut)
	);

	// every way reads and writes the same set
	for (genvar w = 0; w < `TLB_WAYS; w++)
	begin : gWay
		tlbWayArray way (
			.clock(clock),
			.reset(reset),
			.hold(hold),
			.invalidate(invalidate),
			.readIndex(readIndex),
			.writeIndex(writeIndex),
			.writeEnable(writeEnable),
			.writeEntry(newSet.entries[w]),
			.writeValid(newSet.valid[w]),
			.readEntry(readSet.entries[w]),
			.readValid(readSet.valid[w])
		);
	end

	tlbMatch match (
		.set(readSet),
		.addr(stageReq.addr),
		.asid(ctrl.asid),
		.hit(hit),
		.hitWay(hitWay),
		.physAddr(physAddr)
	);

	tlbReplace replace (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.req(stageReq),
		.lookupActive(lookupActive),
		.set(readSet),
		.hit(hit),
		.hitWay(hitWay),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.newSet(newSet)
	);

endmodule

//--- tb/tlb_chk.sv
// output checks of the TLB top level
// bound into mmuTlb by the testbench
`include "tlb_cfg.svh"

module tlb_chk
	import tlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input memReq_t reqOut,
	input tlbExc_t excOut
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// reset empties the output slot
	assert property (@(posedge clock) reset |=> reqOut.op == IDLE)
	else
	begin
		$error("reqOut is not IDLE after reset");
		failCount++;
	end

	// a held pipeline keeps its outputs
	assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable(reqOut) && $stable(excOut))
	else
	begin
		$error("outputs changed while hold was high");
		failCount++;
	end

	assert property (@(posedge clock) disable iff (reset)
		reqOut.missFlag |-> excOut.code == `TLB_EXC_MISS)
	else
	begin
		$error("missFlag set without the miss exception code");
		failCount++;
	end

endmodule

//--- tb/tlbTb.sv
// directed testbench for the four-way TLB
// keeps a model of every set and checks each response against it
`include "tlb_cfg.svh"

module tlbTb
	import tlbPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESPONSE_TIMEOUT = 20;

	logic clock;
	logic reset;
	logic hold;
	mmuCtrl_t ctrl;
	memReq_t reqIn;
	memReq_t reqOut;
	tlbExc_t excOut;

	logic [31:0] rngState = 32'hd611;
	logic [15:0] seqCount = '0;
	tlbEntry_t modelEntry [`TLB_SETS][`TLB_WAYS];
	logic modelValid [`TLB_SETS][`TLB_WAYS];

	mmuTlb mmuTlb_inst (.*);

	bind mmuTlb tlb_chk chk (.*);

	always #4 clock = ~clock;

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic logic [`TLB_ADDR_W-1:0] randomAddr();
		return `TLB_ADDR_W'({nextRandom(), nextRandom()});
	endfunction

	// bit 35 low keeps the page out of the bypass windows
	function automatic logic [`TLB_VPN_W-1:0] vpnInSet(input tlbIndex_t idx);
		return {1'b0, 29'(nextRandom()), idx};
	endfunction

	function automatic logic [`TLB_ADDR_W-1:0] pageAddr(input logic [`TLB_VPN_W-1:0] vpn);
		return {vpn, 12'(nextRandom())};
	endfunction

	function automatic tlbEntry_t makeEntry(input logic [`TLB_VPN_W-1:0] vpn);
		tlbEntry_t entry;
		entry.vpn = vpn;
		entry.ppn = `TLB_VPN_W'({nextRandom(), nextRandom()});
		entry.asid = ctrl.asid;
		return entry;
	endfunction

	function automatic memReq_t makeReq(input tlbOp_e op, input logic [`TLB_ADDR_W-1:0] addr);
		memReq_t req;
		req.op = op;
		req.missFlag = 1'b0;
		req.seq = seqCount;
		req.addr = addr;
		req.data = {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
		seqCount++;
		return req;
	endfunction

	function automatic void clearModel();
		for (int s = 0; s < `TLB_SETS; s++)
			for (int w = 0; w < `TLB_WAYS; w++)
				modelValid[s][w] = 1'b0;
	endfunction

	// expected response of one LDX or STX with hit promotion in the model
	function automatic void modelAccess(input memReq_t req, output memReq_t expReq,
		output tlbExc_t expExc);
		tlbIndex_t idx;
		tlbEntry_t found;
		logic [3:0] top;
		int hitWay;
		int w;
		expReq = req;
		expExc = '0;
		top = req.addr[47:44];
		idx = req.addr[17:12];
		hitWay = -1;
		if (!ctrl.enable || top == `TLB_WIN_MMIO)
			return;
		if (top == `TLB_WIN_PHYS_C || top == `TLB_WIN_PHYS_D)
		begin
			expReq.addr[47:44] = `TLB_WIN_PHYS_C;
			return;
		end
		// lowest matching way wins
		for (w = `TLB_WAYS - 1; w >= 0; w--)
			if (modelValid[idx][w] && modelEntry[idx][w].vpn == req.addr[47:12]
				&& modelEntry[idx][w].asid == ctrl.asid)
				hitWay = w;
		if (hitWay < 0)
		begin
			expReq.addr = {`TLB_MISS_PAGE, req.addr[11:0]};
			expReq.missFlag = 1'b1;
			expExc.code = `TLB_EXC_MISS;
			expExc.faultAddr = req.addr;
			return;
		end
		found = modelEntry[idx][hitWay];
		expReq.addr = {found.ppn, req.addr[11:0]};
		if (expReq.addr[47:44] == 4'h0)
			expReq.addr[47:44] = `TLB_WIN_PHYS_C;
		for (w = hitWay; w > 0; w--)
		begin
			modelEntry[idx][w] = modelEntry[idx][w-1];
			modelValid[idx][w] = modelValid[idx][w-1];
		end
		modelEntry[idx][0] = found;
		modelValid[idx][0] = 1'b1;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compareReq(input string testName, input memReq_t expected,
		input memReq_t actual);
		if (actual !== expected)
			failRun($sformatf("mismatch %s reqOut expected %h actual %h",
				testName, expected, actual));
	endtask

	task automatic compareExc(input string testName, input tlbExc_t expected,
		input tlbExc_t actual);
		if (actual !== expected)
			failRun($sformatf("mismatch %s excOut expected %h actual %h",
				testName, expected, actual));
	endtask

	// one slot in and its result out with an optional hold in stage 1
	task automatic runRequest(input string testName, input memReq_t req, input int holdCycles,
		output memReq_t gotReq, output tlbExc_t gotExc);
		int cycles;
		@(posedge clock);
		#1;
		reqIn = req;
		@(posedge clock);
		#1;
		reqIn = '0;
		hold = (holdCycles > 0);
		// the output keeps the empty slot that went ahead of the request
		repeat (holdCycles)
		begin
			@(posedge clock);
			#1;
			compareReq({testName, " held"}, '0, reqOut);
			compareExc({testName, " held"}, '0, excOut);
		end
		hold = 1'b0;
		cycles = 0;
		while (reqOut.op == IDLE)
		begin
			if (cycles == RESPONSE_TIMEOUT)
				failRun($sformatf("%s got no response on reqOut within %0d cycles",
					testName, RESPONSE_TIMEOUT));
			@(posedge clock);
			#1;
			cycles++;
		end
		gotReq = reqOut;
		gotExc = excOut;
	endtask

	task automatic checkAccess(input string testName, input tlbOp_e op,
		input logic [`TLB_ADDR_W-1:0] addr, input int holdCycles);
		memReq_t req;
		memReq_t expReq;
		memReq_t gotReq;
		tlbExc_t expExc;
		tlbExc_t gotExc;
		req = makeReq(op, addr);
		modelAccess(req, expReq, expExc);
		runRequest(testName, req, holdCycles, gotReq, gotExc);
		compareReq(testName, expReq, gotReq);
		compareExc(testName, expExc, gotExc);
	endtask

	// LDTLB and INVTLB leave the pipe unchanged
	task automatic issueCommand(input string testName, input tlbOp_e op, input tlbEntry_t entry);
		memReq_t req;
		memReq_t gotReq;
		tlbExc_t gotExc;
		tlbIndex_t idx;
		int w;
		req = makeReq(op, randomAddr());
		req.data[$bits(tlbEntry_t)-1:0] = entry;
		idx = entry.vpn[`TLB_INDEX_W-1:0];
		if (op == INVTLB)
			clearModel();
		else
		begin
			for (w = `TLB_WAYS - 1; w > 0; w--)
			begin
				modelEntry[idx][w] = modelEntry[idx][w-1];
				modelValid[idx][w] = modelValid[idx][w-1];
			end
			modelEntry[idx][0] = entry;
			modelValid[idx][0] = 1'b1;
		end
		runRequest(testName, req, 0, gotReq, gotExc);
		compareReq(testName, req, gotReq);
		compareExc(testName, '0, gotExc);
	endtask

	task automatic disabledPassThrough();
		ctrl = '{enable: 1'b0, asid: 16'(nextRandom())};
		checkAccess("disabled ldx", LDX, randomAddr(), 0);
		checkAccess("disabled stx", STX, randomAddr(), 0);
	endtask

	// TLB is still empty here
	task automatic windowBypass();
		ctrl.enable = 1'b1;
		checkAccess("phys window", LDX, {`TLB_WIN_PHYS_D, 44'(randomAddr())}, 0);
		checkAccess("mmio window", STX, {`TLB_WIN_MMIO, 44'(randomAddr())}, 0);
	endtask

	task automatic translateAndAsidMiss();
		tlbEntry_t entry;
		ctrl = '{enable: 1'b1, asid: 16'(nextRandom())};
		entry = makeEntry(vpnInSet(tlbIndex_t'(nextRandom())));
		issueCommand("translate load", LDTLB, entry);
		checkAccess("translate hit", LDX, pageAddr(entry.vpn), 0);
		entry = makeEntry(vpnInSet(tlbIndex_t'(nextRandom())));
		entry.ppn[35:32] = 4'h0;
		issueCommand("low ppn load", LDTLB, entry);
		checkAccess("low ppn hit", STX, pageAddr(entry.vpn), 0);
		ctrl.asid = ~ctrl.asid;
		checkAccess("asid miss", LDX, pageAddr(entry.vpn), 0);
	endtask

	task automatic setEviction();
		tlbEntry_t group [5];
		tlbIndex_t idx;
		int i;
		idx = tlbIndex_t'(nextRandom());
		for (i = 0; i < 5; i++)
		begin
			group[i] = makeEntry(vpnInSet(idx));
			issueCommand("evict load", LDTLB, group[i]);
		end
		checkAccess("first evicted", LDX, pageAddr(group[0].vpn), 0);
		checkAccess("second kept", LDX, pageAddr(group[1].vpn), 0);
		// the oldest entry is used again before the fifth load
		idx = idx + 1'b1;
		for (i = 0; i < 5; i++)
		begin
			group[i] = makeEntry(vpnInSet(idx));
			if (i == 4)
				checkAccess("oldest promoted", LDX, pageAddr(group[0].vpn), 0);
			issueCommand("reload", LDTLB, group[i]);
		end
		checkAccess("promoted kept", LDX, pageAddr(group[0].vpn), 0);
		checkAccess("second evicted", STX, pageAddr(group[1].vpn), 0);
	endtask

	task automatic invalidateAll();
		tlbEntry_t entry;
		entry = makeEntry(vpnInSet(tlbIndex_t'(nextRandom())));
		issueCommand("invalidate load", LDTLB, entry);
		checkAccess("before invtlb", LDX, pageAddr(entry.vpn), 0);
		issueCommand("invtlb", INVTLB, entry);
		checkAccess("after invtlb", LDX, pageAddr(entry.vpn), 0);
	endtask

	task automatic holdInFlight();
		tlbEntry_t entry;
		entry = makeEntry(vpnInSet(tlbIndex_t'(nextRandom())));
		issueCommand("hold load", LDTLB, entry);
		checkAccess("hold hit", LDX, pageAddr(entry.vpn), 5);
		checkAccess("hold miss", STX, pageAddr(vpnInSet(tlbIndex_t'(nextRandom()))), 4);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		hold = 1'b0;
		ctrl = '0;
		reqIn = '0;
		clearModel();
		repeat (10)
			@(posedge clock);
		#1;
		reset = 1'b0;
		disabledPassThrough();
		windowBypass();
		translateAndAsidMiss();
		setEviction();
		invalidateAll();
		holdInFlight();
		repeat (2)
			@(posedge clock);
		if (mmuTlb_inst.chk.failCount != 0)
			failRun("the bound checker reported assertion failures");
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

//--- Bender.yml
package:
  name: mmu_tlb

sources:
  - include_dirs:
      - source
    files:
      - source/tlbPkg.sv
      - source/tlbWayArray.sv
      - source/tlbMatch.sv
      - source/tlbReplace.sv
      - source/tlbPipe.sv
      - source/mmuTlb.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tlb_chk.sv
      - tb/tlbTb.sv

//--- sim.f
+incdir+source
source/tlbPkg.sv
source/tlbWayArray.sv
source/tlbMatch.sv
source/tlbReplace.sv
source/tlbPipe.sv
source/mmuTlb.sv
tb/tlb_chk.sv
tb/tlbTb.sv
